// ==== bus_decoder.sv ====
/*
 * Input stage. Classifies each request against the ROM and RAM windows and
 * registers it with its target and region-relative word index.
 */
`include "harness_macros.svh"

module bus_decoder (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`HARNESS_ADDR_W-1:0] addr_i,
  input  logic [`HARNESS_BE_W-1:0]   be_i,
  input  logic [`HARNESS_DATA_W-1:0] wdata_i,
  mem_req_if.dec                     req
);
  import harness_bus_pkg::*;

  localparam int unsigned IdxLsb = $clog2(`HARNESS_BE_W);
  localparam int unsigned IdxW   = $bits(word_idx_t);
  localparam logic [`HARNESS_ADDR_W-1:0] RomBytes = `HARNESS_ROM_WORDS * `HARNESS_BE_W;
  localparam logic [`HARNESS_ADDR_W-1:0] RamBytes = `HARNESS_RAM_WORDS * `HARNESS_BE_W;

  logic [`HARNESS_ADDR_W-1:0] rom_off;
  logic [`HARNESS_ADDR_W-1:0] ram_off;
  logic                       in_rom;
  logic                       in_ram;
  bus_op_e                    op_d;
  target_e                    target_d;
  word_idx_t                  idx_d;

  // ------------------------------
  // Address match
  // ------------------------------
  // Below the base the offset wraps high and fails the size check
  assign rom_off = addr_i - `HARNESS_ROM_BASE;
  assign ram_off = addr_i - `HARNESS_RAM_BASE;
  assign in_rom  = (rom_off < RomBytes);
  assign in_ram  = (ram_off < RamBytes);
  assign op_d    = we_i ? OP_WRITE : OP_READ;

  always_comb begin
    if (in_ram) begin
      target_d = TGT_RAM;
      idx_d    = ram_off[IdxLsb +: IdxW];
    end else if (in_rom && op_d == OP_READ) begin
      target_d = TGT_ROM;
      idx_d    = rom_off[IdxLsb +: IdxW];
    end else begin
      // ROM writes and unmapped addresses
      target_d = TGT_ERR;
      idx_d    = '0;
    end
  end

  // ------------------------------
  // Request register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      req.op     <= op_d;
      req.target <= target_d;
      req.idx    <= idx_d;
      req.be     <= be_i;
      req.wdata  <= wdata_i;
    end
  end

endmodule

// ==== debug_gate.sv ====
/*
 * Keeps the external debug request off for a fixed time after reset and
 * whenever debug is disabled. Passes it through without delay once armed.
 */
`include "harness_macros.svh"

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);
  import harness_dbg_pkg::*;

  holdoff_cnt_t cnt_q;
  dbg_state_e   state;

  // Armed once the counter has run out
  assign state = (cnt_q != '0) ? DBG_HOLDOFF : DBG_ARMED;

  // ------------------------------
  // Hold-off counter
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= holdoff_cnt_t'(`HARNESS_DBG_HOLDOFF);
    end else if (state == DBG_HOLDOFF) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (state == DBG_ARMED) && debug_enable_i && debug_req_i;

endmodule

// ==== harness_asserts.sv ====
/*
 * Port-level checks of the harness, with a shadow RAM and a hold-off model.
 * Bound into harness_top and fed only by its ports.
 */
`include "harness_macros.svh"

module harness_asserts (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       req_i,
  input logic                       we_i,
  input logic [`HARNESS_ADDR_W-1:0] addr_i,
  input logic [`HARNESS_BE_W-1:0]   be_i,
  input logic [`HARNESS_DATA_W-1:0] wdata_i,
  input logic                       rvalid_o,
  input logic [`HARNESS_DATA_W-1:0] rdata_o,
  input logic                       err_o,
  input logic                       debug_req_i,
  input logic                       debug_enable_i,
  input logic                       debug_req_o
);
  import harness_bus_pkg::*;
  import harness_dbg_pkg::*;

  localparam int unsigned RamIdxW = $clog2(`HARNESS_RAM_WORDS);
  localparam logic [31:0] RomEnd = `HARNESS_ROM_BASE + `HARNESS_ROM_WORDS * 8;
  localparam logic [31:0] RamEnd = `HARNESS_RAM_BASE + `HARNESS_RAM_WORDS * 8;

  int unsigned                fail_cnt = 0;
  logic                       reset_held_q = 1'b0;
  logic [`HARNESS_DATA_W-1:0] shadow_ram [`HARNESS_RAM_WORDS];
  target_e                    req_tgt;
  logic [31:0]                req_word;
  logic [`HARNESS_DATA_W-1:0] req_rdata;
  logic                       v1_q, v2_q, err1_q, err2_q;
  logic [`HARNESS_DATA_W-1:0] data1_q, data2_q;
  int unsigned                run_cycles_q;
  dbg_state_e                 dbg_state;

  // ------------------------------
  // Expected response model
  // ------------------------------
  always_comb begin
    req_word = '0;
    req_tgt  = TGT_ERR;
    if (addr_i >= `HARNESS_RAM_BASE && addr_i < RamEnd) begin
      req_tgt  = TGT_RAM;
      req_word = (addr_i - `HARNESS_RAM_BASE) >> 3;
    end else if (addr_i >= `HARNESS_ROM_BASE && addr_i < RomEnd && !we_i) begin
      req_tgt  = TGT_ROM;
      req_word = (addr_i - `HARNESS_ROM_BASE) >> 3;
    end
  end

  always_comb begin
    req_rdata = '0;
    if (!we_i && req_tgt == TGT_ROM) req_rdata = {`HARNESS_ROM_TAG, req_word};
    if (!we_i && req_tgt == TGT_RAM) req_rdata = shadow_ram[req_word[RamIdxW-1:0]];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else begin
      v1_q <= req_i;
      v2_q <= v1_q;
    end
  end

  always_ff @(posedge clk_i) begin
    reset_held_q <= !rst_ni;
    if (rst_ni && req_i) begin
      err1_q  <= (req_tgt == TGT_ERR);
      data1_q <= req_rdata;
    end
    err2_q  <= err1_q;
    data2_q <= data1_q;
    // Shadow RAM follows the port-level writes
    if (rst_ni && req_i && we_i && req_tgt == TGT_RAM) begin
      for (int b = 0; b < `HARNESS_BE_W; b++) begin
        if (be_i[b]) shadow_ram[req_word[RamIdxW-1:0]][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // Counts cycles after reset release up to the hold-off length
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_cycles_q <= 0;
    end else if (run_cycles_q < `HARNESS_DBG_HOLDOFF) begin
      run_cycles_q <= run_cycles_q + 1;
    end
  end

  assign dbg_state = (run_cycles_q < `HARNESS_DBG_HOLDOFF) ? DBG_HOLDOFF : DBG_ARMED;

  // ------------------------------
  // Checks
  // ------------------------------
  a_reset_low: assert property (@(posedge clk_i)
    (!rst_ni && reset_held_q) |-> (!rvalid_o && !err_o && !debug_req_o))
    else begin
      fail_cnt++;
      $error("Outputs are not low during reset");
    end

  a_one_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_o == v2_q)
    else begin
      fail_cnt++;
      $error("Response pulse does not follow its request");
    end

  a_err_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_o == (v2_q && err2_q))
    else begin
      fail_cnt++;
      $error("MISMATCH err_flag expected %b actual %b",
             $sampled(v2_q && err2_q), $sampled(err_o));
    end

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> rdata_o == data2_q)
    else begin
      fail_cnt++;
      $error("MISMATCH rdata expected %h actual %h", $sampled(data2_q), $sampled(rdata_o));
    end

  a_dbg_holdoff: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dbg_state == DBG_HOLDOFF) |-> !debug_req_o)
    else begin
      fail_cnt++;
      $error("Debug request passed during the hold-off");
    end

  a_dbg_pass: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dbg_state == DBG_ARMED) |-> debug_req_o == (debug_req_i && debug_enable_i))
    else begin
      fail_cnt++;
      $error("MISMATCH debug_req expected %b actual %b",
             $sampled(debug_req_i && debug_enable_i), $sampled(debug_req_o));
    end

endmodule

bind harness_top harness_asserts u_asserts (.*);

// ==== harness_bus_pkg.sv ====
/*
 * Types of the simple request/response bus between the decoder, the memories
 * and the response mux. Imported inside the bodies of the modules that use them.
 */
`include "harness_macros.svh"

package harness_bus_pkg;

  // ------------------------------
  // Word addressing
  // ------------------------------
  // Index wide enough for the RAM and shared by the ROM
  typedef logic [$clog2(`HARNESS_RAM_WORDS)-1:0] word_idx_t;

  // ------------------------------
  // Request classification
  // ------------------------------
  // Target picked by the address decoder
  typedef enum logic [1:0] {
    TGT_ROM = 2'd0,
    TGT_RAM = 2'd1,
    TGT_ERR = 2'd2
  } target_e;

  // Access direction
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

endpackage

// ==== harness_dbg_pkg.sv ====
/*
 * Types of the debug request gate that holds debug off after reset.
 */
`include "harness_macros.svh"

package harness_dbg_pkg;

  // Wide enough to hold the full hold-off count
  typedef logic [$clog2(`HARNESS_DBG_HOLDOFF + 1)-1:0] holdoff_cnt_t;

  // Gate state
  typedef enum logic {
    DBG_HOLDOFF = 1'b0,
    DBG_ARMED   = 1'b1
  } dbg_state_e;

endpackage

// ==== harness_ifs.sv ====
/*
 * Internal channels of the harness. mem_req_if carries the decoded request into
 * the memories and mem_rsp_if carries the read results to the response mux.
 */
`include "harness_macros.svh"

interface mem_req_if;
  import harness_bus_pkg::*;

  logic                       valid;
  bus_op_e                    op;
  target_e                    target;
  word_idx_t                  idx;
  logic [`HARNESS_BE_W-1:0]   be;
  logic [`HARNESS_DATA_W-1:0] wdata;

  modport dec (output valid, op, target, idx, be, wdata);
  modport mem (input  valid, op, target, idx, be, wdata);
endinterface

interface mem_rsp_if;
  import harness_bus_pkg::*;

  logic                       valid;
  bus_op_e                    op;
  target_e                    target;
  logic [`HARNESS_DATA_W-1:0] rom_rdata;
  logic [`HARNESS_DATA_W-1:0] ram_rdata;

  modport mem (output valid, op, target, rom_rdata, ram_rdata);
  modport sel (input  valid, op, target, rom_rdata, ram_rdata);
endinterface

// ==== harness_macros.svh ====
/*
 * Shared widths, address map and debug hold-off length for the memory harness.
 * Included by the packages and by every RTL file that sizes a port or a register.
 */
`ifndef HARNESS_MACROS_SVH
`define HARNESS_MACROS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define HARNESS_ADDR_W 32
`define HARNESS_DATA_W 64
`define HARNESS_BE_W   8

// ------------------------------
// Address map
// ------------------------------
// Boot ROM
`define HARNESS_ROM_BASE  32'h0000_1000
`define HARNESS_ROM_WORDS 16
// Main RAM
`define HARNESS_RAM_BASE  32'h8000_0000
`define HARNESS_RAM_WORDS 256

// Upper half of every ROM word
`define HARNESS_ROM_TAG 32'hB007_0000

// Cycles after reset release before debug requests pass
`define HARNESS_DBG_HOLDOFF 20

`endif

// ==== harness_top.sv ====
/*
 * Top of the memory harness. Routes plain bus requests to the boot ROM, the RAM
 * or the error responder, and gates the external debug request.
 */
`include "harness_macros.svh"

module harness_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Request side
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`HARNESS_ADDR_W-1:0] addr_i,
  input  logic [`HARNESS_BE_W-1:0]   be_i,
  input  logic [`HARNESS_DATA_W-1:0] wdata_i,
  // Response side
  output logic                       rvalid_o,
  output logic [`HARNESS_DATA_W-1:0] rdata_o,
  output logic                       err_o,
  // Debug
  input  logic                       debug_req_i,
  input  logic                       debug_enable_i,
  output logic                       debug_req_o
);

  mem_req_if req_bus ();
  mem_rsp_if rsp_bus ();

  // ------------------------------
  // Request path
  // ------------------------------
  bus_decoder u_bus_decoder (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .req_i   ( req_i   ),
    .we_i    ( we_i    ),
    .addr_i  ( addr_i  ),
    .be_i    ( be_i    ),
    .wdata_i ( wdata_i ),
    .req     ( req_bus )
  );

  // ROM and RAM storage
  mem_bank u_mem_bank (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req    ( req_bus ),
    .rsp    ( rsp_bus )
  );

  // ------------------------------
  // Response path
  // ------------------------------
  resp_select u_resp_select (
    .rsp      ( rsp_bus  ),
    .rvalid_o ( rvalid_o ),
    .err_o    ( err_o    ),
    .rdata_o  ( rdata_o  )
  );

  // ------------------------------
  // Debug request gate
  // ------------------------------
  debug_gate u_debug_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

// ==== mem_bank.sv ====
/*
 * Storage stage with the boot ROM image and the byte-enabled RAM. Both are read
 * synchronously, and the request tags are delayed to line up with the data.
 */
`include "harness_macros.svh"

module mem_bank (
  input  logic   clk_i,
  input  logic   rst_ni,
  mem_req_if.mem req,
  mem_rsp_if.mem rsp
);
  import harness_bus_pkg::*;

  localparam int unsigned RomIdxW = $clog2(`HARNESS_ROM_WORDS);

  typedef logic [`HARNESS_ROM_WORDS-1:0][`HARNESS_DATA_W-1:0] rom_image_t;

  // Word i holds the tag above its own index
  function automatic rom_image_t rom_image();
    rom_image_t img;
    for (int i = 0; i < `HARNESS_ROM_WORDS; i++) begin
      img[i] = {`HARNESS_ROM_TAG, 32'(i)};
    end
    return img;
  endfunction

  localparam rom_image_t RomImage = rom_image();

  logic [`HARNESS_DATA_W-1:0] ram_q [`HARNESS_RAM_WORDS];
  logic [`HARNESS_DATA_W-1:0] rom_rdata_q;
  logic [`HARNESS_DATA_W-1:0] ram_rdata_q;
  logic                       rom_re;
  logic                       ram_re;
  logic                       ram_we;
  logic                       valid_q;
  bus_op_e                    op_q;
  target_e                    target_q;

  assign rom_re = req.valid && (req.target == TGT_ROM);
  assign ram_re = req.valid && (req.target == TGT_RAM) && (req.op == OP_READ);
  assign ram_we = req.valid && (req.target == TGT_RAM) && (req.op == OP_WRITE);

  // ------------------------------
  // Memory arrays
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (ram_we) begin
      for (int b = 0; b < `HARNESS_BE_W; b++) begin
        if (req.be[b]) begin
          ram_q[req.idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
    if (ram_re) begin
      ram_rdata_q <= ram_q[req.idx];
    end
    if (rom_re) begin
      rom_rdata_q <= RomImage[req.idx[RomIdxW-1:0]];
    end
  end

  // ------------------------------
  // Tag pipeline
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.valid) begin
      op_q     <= req.op;
      target_q <= req.target;
    end
  end

  assign rsp.valid     = valid_q;
  assign rsp.op        = op_q;
  assign rsp.target    = target_q;
  assign rsp.rom_rdata = rom_rdata_q;
  assign rsp.ram_rdata = ram_rdata_q;

endmodule

// ==== resp_select.sv ====
/*
 * Output stage. Picks the read data for the response and flags accesses that
 * went to the error target. Purely combinational.
 */
`include "harness_macros.svh"

module resp_select (
  mem_rsp_if.sel                     rsp,
  output logic                       rvalid_o,
  output logic                       err_o,
  output logic [`HARNESS_DATA_W-1:0] rdata_o
);
  import harness_bus_pkg::*;

  logic is_read;

  assign is_read  = rsp.valid && (rsp.op == OP_READ);
  assign rvalid_o = rsp.valid;
  assign err_o    = rsp.valid && (rsp.target == TGT_ERR);

  // Writes and errors return zero data
  always_comb begin
    rdata_o = '0;
    if (is_read) begin
      case (rsp.target)
        TGT_ROM: rdata_o = rsp.rom_rdata;
        TGT_RAM: rdata_o = rsp.ram_rdata;
        default: rdata_o = '0;
      endcase
    end
  end

endmodule

// ==== sources.f ====
+incdir+.
harness_bus_pkg.sv
harness_dbg_pkg.sv
harness_ifs.sv
bus_decoder.sv
mem_bank.sv
resp_select.sv
debug_gate.sv
harness_top.sv
harness_asserts.sv
tb_harness.sv

// ==== tb_harness.sv ====
/*
 * Testbench of the memory harness. Drives debug, ROM, RAM and error traffic
 * while the bound checks judge every response, then reports each test.
 */
`include "harness_macros.svh"

module tb_harness;

  localparam int unsigned ClkPeriod   = 4;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned RamWords    = 8;
  localparam int unsigned RamPartials = 24;
  // Cycle budget of each test
  localparam int unsigned DebugCycles = `HARNESS_DBG_HOLDOFF + 30;
  localparam int unsigned RomCycles   = `HARNESS_ROM_WORDS + 10;
  localparam int unsigned RamCycles   = 2 * RamWords + RamPartials + RamPartials / 4 + 10;
  localparam int unsigned ErrCycles   = 20;
  localparam int unsigned WatchdogCycles =
    ResetCycles + DebugCycles + RomCycles + RamCycles + ErrCycles + 100;

  logic                       clk_i = 1'b0;
  logic                       rst_ni, req_i, we_i;
  logic [`HARNESS_ADDR_W-1:0] addr_i;
  logic [`HARNESS_BE_W-1:0]   be_i;
  logic [`HARNESS_DATA_W-1:0] wdata_i;
  logic                       rvalid_o, err_o;
  logic [`HARNESS_DATA_W-1:0] rdata_o;
  logic                       debug_req_i, debug_enable_i, debug_req_o;

  logic [31:0] rng_state = 32'h1a5ccf62;
  logic [31:0] ram_addr [RamWords];
  int unsigned req_cnt = 0;
  int unsigned rsp_cnt = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  int unsigned fails_before = 0;

  harness_top dut0 (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (rvalid_o) rsp_cnt <= rsp_cnt + 1;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  task automatic send(input logic we, input logic [31:0] addr, input logic [7:0] be,
                      input logic [63:0] data);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    be_i    <= be;
    wdata_i <= data;
    req_cnt++;
  endtask

  // Stop requesting and wait for every response
  task automatic drain();
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    while (rsp_cnt != req_cnt) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic report_test(input string name);
    int unsigned new_fails;
    new_fails = dut0.u_asserts.fail_cnt - fails_before;
    fails_before = dut0.u_asserts.fail_cnt;
    tests_run++;
    if (new_fails == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d failed checks", name, new_fails);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic debug_test();
    logic [31:0] r;
    for (int i = 0; i < `HARNESS_DBG_HOLDOFF + 24; i++) begin
      r = rand32();
      @(posedge clk_i);
      debug_req_i    <= r[4];
      // Enable drops for a stretch once the gate is armed
      debug_enable_i <= !(i >= `HARNESS_DBG_HOLDOFF + 8 && i < `HARNESS_DBG_HOLDOFF + 16);
    end
    @(posedge clk_i);
    debug_req_i    <= 1'b0;
    debug_enable_i <= 1'b1;
    @(negedge clk_i);
    report_test("debug_holdoff");
  endtask

  task automatic rom_test();
    for (int i = 0; i < `HARNESS_ROM_WORDS; i++) begin
      send(1'b0, `HARNESS_ROM_BASE + i * 8, 8'hff, '0);
    end
    drain();
    report_test("rom_read");
  endtask

  task automatic ram_test();
    logic [31:0] r;
    int unsigned k;
    // Full-word writes first so no read returns unknown bytes
    for (int i = 0; i < RamWords; i++) begin
      r = rand32();
      ram_addr[i] = `HARNESS_RAM_BASE + {21'd0, r[7:0], 3'd0};
      send(1'b1, ram_addr[i], 8'hff, {rand32(), rand32()});
    end
    for (int i = 0; i < RamPartials; i++) begin
      r = rand32();
      k = r[31:16] % RamWords;
      send(1'b1, ram_addr[k], r[15:8], {rand32(), rand32()});
      if (i % 4 == 3) send(1'b0, ram_addr[k], 8'hff, '0);
    end
    for (int i = 0; i < RamWords; i++) begin
      send(1'b0, ram_addr[i], 8'hff, '0);
    end
    drain();
    report_test("ram_rw");
  endtask

  task automatic error_test();
    send(1'b1, `HARNESS_ROM_BASE, 8'hff, {rand32(), rand32()});
    send(1'b1, `HARNESS_ROM_BASE + 40, 8'h0f, {rand32(), rand32()});
    send(1'b0, 32'h0000_0000, 8'hff, '0);
    send(1'b0, `HARNESS_ROM_BASE - 8, 8'hff, '0);
    send(1'b1, `HARNESS_ROM_BASE + `HARNESS_ROM_WORDS * 8, 8'hff, {rand32(), rand32()});
    send(1'b0, `HARNESS_RAM_BASE - 8, 8'hff, '0);
    send(1'b1, `HARNESS_RAM_BASE + `HARNESS_RAM_WORDS * 8, 8'hff, {rand32(), rand32()});
    send(1'b0, 32'hffff_fff8, 8'hff, '0);
    // ROM contents after the rejected writes
    send(1'b0, `HARNESS_ROM_BASE, 8'hff, '0);
    send(1'b0, `HARNESS_ROM_BASE + 40, 8'hff, '0);
    drain();
    report_test("errors");
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    rst_ni         = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    debug_req_i    = 1'b0;
    debug_enable_i = 1'b0;
    @(posedge clk_i);
    debug_req_i    <= 1'b1;
    debug_enable_i <= 1'b1;
    repeat (ResetCycles - 1) @(posedge clk_i);
    rst_ni <= 1'b1;
    debug_test();
    rom_test();
    ram_test();
    error_test();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, dut0.u_asserts.fail_cnt);
    if (tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
    $display("Verification failed");
    $finish;
  end

endmodule
